/* common/csr_map_pkg.sv */
// csr map package: CSR numbers, word layouts and the access request and select types
`default_nettype none

package csr_map_pkg;

    localparam int CSR_NUM_W = 14;
    localparam int CSR_W     = 32;
    localparam int MAX_SAVE  = 4;

    // csr numbers
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD      = 14'h00;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD      = 14'h01;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG      = 14'h04;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT     = 14'h05;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA       = 14'h06;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV      = 14'h07;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY    = 14'h0c;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE_BASE = 14'h30;  // SAVE0, the rest follow
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG      = 14'h41;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL      = 14'h42;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR     = 14'h44;

    localparam logic [12:0] ECFG_LIE_MASK = 13'h1bff;  // bit 10 reserved

    typedef struct packed {
        logic                 we;
        logic [CSR_NUM_W-1:0] num;
        logic [CSR_W-1:0]     wmask;
        logic [CSR_W-1:0]     wvalue;
    } csr_req_t;

    // one select bit per mapped csr
    typedef struct packed {
        logic [MAX_SAVE-1:0] save;
        logic                crmd;
        logic                prmd;
        logic                ecfg;
        logic                estat;
        logic                era;
        logic                badv;
        logic                eentry;
        logic                tcfg;
        logic                tval;
        logic                ticlr;
    } csr_sel_t;

    typedef struct packed {
        logic [22:0] rsv;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] rsv;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    typedef struct packed {
        logic        rsv31;
        logic [8:0]  esubcode;
        logic [5:0]  ecode;
        logic [2:0]  rsv15;
        logic [12:0] is;
    } estat_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    typedef struct packed {
        crmd_t            crmd;
        prmd_t            prmd;
        logic [CSR_W-1:0] ecfg;
        estat_t           estat;
        logic [CSR_W-1:0] era;
        logic [CSR_W-1:0] badv;
        logic [CSR_W-1:0] eentry;
    } trap_rd_t;

    typedef struct packed {
        tcfg_t            tcfg;
        logic [CSR_W-1:0] tval;
        logic [CSR_W-1:0] ticlr;
    } timer_rd_t;

    // masked software write, unmasked bits keep the old value
    function automatic logic [CSR_W-1:0] csr_merge(
        input logic [CSR_W-1:0] old_val,
        input logic [CSR_W-1:0] wmask,
        input logic [CSR_W-1:0] wvalue
    );
        return (wmask & wvalue) | (~wmask & old_val);
    endfunction

endpackage

`default_nettype wire

/* common/csr_trap_pkg.sv */
// csr trap package: exception codes, the exception pulse and interrupt widths
`default_nettype none

package csr_trap_pkg;

    localparam int HW_INT_W = 8;  // hardware interrupt lines

    // exception codes
    localparam logic [5:0] ECODE_ADE = 6'h8;  // address error
    localparam logic [5:0] ECODE_ALE = 6'h9;  // misaligned access

    localparam logic [8:0] ESUBCODE_ADEF = 9'h0;  // fetch side of ADE

    // exception pulse from writeback
    typedef struct packed {
        logic        ex;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] pc;
        logic [31:0] vaddr;
    } trap_evt_t;

endpackage

`default_nettype wire

/* exception/csr_trap_regs.sv */
// trap csr block: mode, exception status, interrupt enables, entry base and has_int
`timescale 1ns/1ns
`default_nettype none

module csr_trap_regs (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire csr_map_pkg::csr_sel_t       wsel,
    input  wire [csr_map_pkg::CSR_W-1:0]     wmask,
    input  wire [csr_map_pkg::CSR_W-1:0]     wvalue,
    input  wire csr_trap_pkg::trap_evt_t     trap,
    input  wire                              ertn,
    input  wire [csr_trap_pkg::HW_INT_W-1:0] hw_int,
    input  wire                              ipi_int,
    input  wire                              tpend,
    output csr_map_pkg::trap_rd_t            rd,
    output logic                             has_int
);
    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    logic [1:0]          crmd_plv;
    logic                crmd_ie;
    logic [1:0]          prmd_pplv;
    logic                prmd_pie;
    logic [12:0]         ecfg_lie;
    logic [1:0]          is_sw;     // software interrupts
    logic [HW_INT_W-1:0] is_hw;
    logic                is_ipi;
    logic [12:0]         is_all;
    logic [5:0]          ecode;
    logic [8:0]          esubcode;
    logic [CSR_W-1:0]    era;
    logic [CSR_W-1:0]    badv;
    logic [25:0]         eentry_va;
    crmd_t               crmd_wr;
    prmd_t               prmd_wr;
    estat_t              estat_wr;
    logic [CSR_W-1:0]    ecfg_wr;
    logic [CSR_W-1:0]    era_wr;
    logic [CSR_W-1:0]    badv_wr;
    logic [CSR_W-1:0]    eentry_wr;
    logic                addr_err;

    assign is_all = {is_ipi, tpend, 1'b0, is_hw, is_sw};  // bit 10 reserved

    always_comb begin
        rd             = '0;
        rd.crmd.plv    = crmd_plv;
        rd.crmd.ie     = crmd_ie;
        rd.crmd.da     = 1'b1;      // direct address mode only
        rd.prmd.pplv   = prmd_pplv;
        rd.prmd.pie    = prmd_pie;
        rd.ecfg        = CSR_W'(ecfg_lie);
        rd.estat.is    = is_all;
        rd.estat.ecode = ecode;
        rd.estat.esubcode = esubcode;
        rd.era         = era;
        rd.badv        = badv;
        rd.eentry      = {eentry_va, 6'b0};
    end

    // word after a software write
    assign crmd_wr   = crmd_t'(csr_merge(rd.crmd, wmask, wvalue));
    assign prmd_wr   = prmd_t'(csr_merge(rd.prmd, wmask, wvalue));
    assign estat_wr  = estat_t'(csr_merge(rd.estat, wmask, wvalue));
    assign ecfg_wr   = csr_merge(rd.ecfg, wmask, wvalue);
    assign era_wr    = csr_merge(era, wmask, wvalue);
    assign badv_wr   = csr_merge(badv, wmask, wvalue);
    assign eentry_wr = csr_merge(rd.eentry, wmask, wvalue);

    assign addr_err = (trap.ecode == ECODE_ADE) || (trap.ecode == ECODE_ALE);

    assign has_int = crmd_ie && ((is_all & ecfg_lie) != 13'b0);

    // exception beats ertn beats software
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (trap.ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wsel.crmd) begin
            crmd_plv <= crmd_wr.plv;
            crmd_ie  <= crmd_wr.ie;
        end
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            prmd_pplv <= crmd_plv;  // old mode saved on entry
            prmd_pie  <= crmd_ie;
        end else if (wsel.prmd) begin
            prmd_pplv <= prmd_wr.pplv;
            prmd_pie  <= prmd_wr.pie;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie <= 13'b0;
            is_sw    <= 2'b0;
        end else begin
            if (wsel.ecfg)
                ecfg_lie <= ecfg_wr[12:0] & ECFG_LIE_MASK;
            if (wsel.estat)
                is_sw <= estat_wr.is[1:0];
        end
    end

    // interrupt lines sampled every cycle
    always_ff @(posedge clk) begin
        is_hw  <= hw_int;
        is_ipi <= ipi_int;
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            ecode    <= trap.ecode;
            esubcode <= trap.esubcode;
            era      <= trap.pc;
        end else if (wsel.era) begin
            era <= era_wr;
        end

        if (trap.ex && addr_err)
            badv <= (trap.ecode == ECODE_ADE && trap.esubcode == ESUBCODE_ADEF) ?
                    trap.pc : trap.vaddr;  // fetch fault reports pc
        else if (wsel.badv)
            badv <= badv_wr;

        if (wsel.eentry)
            eentry_va <= eentry_wr[31:6];
    end

endmodule

`default_nettype wire

/* sim.f */
common/csr_map_pkg.sv
common/csr_trap_pkg.sv
source/csr_access_decode.sv
exception/csr_trap_regs.sv
timer/csr_timer.sv
source/csr_save_bank.sv
source/csr_read_mux.sv
source/csr_top.sv
tb/csr_tb.sv

/* source/csr_access_decode.sv */
// csr access decoder: matches the request number to one-hot read and write selects
`timescale 1ns/1ns
`default_nettype none

module csr_access_decode #(
    parameter int SAVE_NUM = csr_map_pkg::MAX_SAVE
) (
    input  wire csr_map_pkg::csr_req_t req,
    output csr_map_pkg::csr_sel_t      rsel,
    output csr_map_pkg::csr_sel_t      wsel
);
    import csr_map_pkg::*;

    always_comb begin
        rsel        = '0;
        rsel.crmd   = (req.num == CSR_CRMD);
        rsel.prmd   = (req.num == CSR_PRMD);
        rsel.ecfg   = (req.num == CSR_ECFG);
        rsel.estat  = (req.num == CSR_ESTAT);
        rsel.era    = (req.num == CSR_ERA);
        rsel.badv   = (req.num == CSR_BADV);
        rsel.eentry = (req.num == CSR_EENTRY);
        rsel.tcfg   = (req.num == CSR_TCFG);
        rsel.tval   = (req.num == CSR_TVAL);
        rsel.ticlr  = (req.num == CSR_TICLR);

        // save numbers are consecutive from the base
        for (int i = 0; i < SAVE_NUM; i++) begin
            rsel.save[i] = (req.num == CSR_SAVE_BASE + CSR_NUM_W'(i));
        end
    end

    // write strobe per csr
    always_comb begin
        wsel = req.we ? rsel : '0;
    end

endmodule

`default_nettype wire

/* source/csr_read_mux.sv */
// csr read mux: ORs the selected CSR word onto rvalue, unmapped numbers read 0
`timescale 1ns/1ns
`default_nettype none

module csr_read_mux #(
    parameter int SAVE_NUM = csr_map_pkg::MAX_SAVE
) (
    input  wire csr_map_pkg::csr_sel_t    rsel,
    input  wire csr_map_pkg::trap_rd_t    trap_rd,
    input  wire csr_map_pkg::timer_rd_t   timer_rd,
    input  wire [csr_map_pkg::CSR_W-1:0]  save [SAVE_NUM],
    output logic [csr_map_pkg::CSR_W-1:0] rvalue
);
    import csr_map_pkg::*;

    always_comb begin
        rvalue = '0;
        rvalue |= {CSR_W{rsel.crmd}}   & trap_rd.crmd;
        rvalue |= {CSR_W{rsel.prmd}}   & trap_rd.prmd;
        rvalue |= {CSR_W{rsel.ecfg}}   & trap_rd.ecfg;
        rvalue |= {CSR_W{rsel.estat}}  & trap_rd.estat;
        rvalue |= {CSR_W{rsel.era}}    & trap_rd.era;
        rvalue |= {CSR_W{rsel.badv}}   & trap_rd.badv;
        rvalue |= {CSR_W{rsel.eentry}} & trap_rd.eentry;

        // timer words
        rvalue |= {CSR_W{rsel.tcfg}}  & timer_rd.tcfg;
        rvalue |= {CSR_W{rsel.tval}}  & timer_rd.tval;
        rvalue |= {CSR_W{rsel.ticlr}} & timer_rd.ticlr;

        for (int i = 0; i < SAVE_NUM; i++) begin
            rvalue |= {CSR_W{rsel.save[i]}} & save[i];
        end
    end

endmodule

`default_nettype wire

/* source/csr_save_bank.sv */
// scratch register bank: SAVE_NUM masked 32-bit registers
`timescale 1ns/1ns
`default_nettype none

module csr_save_bank #(
    parameter int SAVE_NUM = csr_map_pkg::MAX_SAVE
) (
    input  wire                          clk,
    input  wire csr_map_pkg::csr_sel_t   wsel,
    input  wire [csr_map_pkg::CSR_W-1:0] wmask,
    input  wire [csr_map_pkg::CSR_W-1:0] wvalue,
    output logic [csr_map_pkg::CSR_W-1:0] save [SAVE_NUM]
);
    import csr_map_pkg::*;

    // one register per save number
    for (genvar i = 0; i < SAVE_NUM; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (wsel.save[i])
                save[i] <= csr_merge(save[i], wmask, wvalue);
        end
    end

endmodule

`default_nettype wire

/* source/csr_top.sv */
// csr file top: decoder, trap registers, timer, save bank and read mux
`timescale 1ns/1ns
`default_nettype none

module csr_top #(
    parameter int SAVE_NUM = 4
) (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire csr_map_pkg::csr_req_t       req,
    input  wire csr_trap_pkg::trap_evt_t     trap,
    input  wire                              ertn,
    input  wire [csr_trap_pkg::HW_INT_W-1:0] hw_int,
    input  wire                              ipi_int,
    output logic [csr_map_pkg::CSR_W-1:0]    rvalue,
    output logic                             has_int
);
    import csr_map_pkg::*;

    csr_sel_t         rsel;
    csr_sel_t         wsel;
    trap_rd_t         trap_rd;
    timer_rd_t        timer_rd;
    logic             tpend;       // timer interrupt into ESTAT
    logic [CSR_W-1:0] save [SAVE_NUM];

    csr_access_decode #(.SAVE_NUM(SAVE_NUM)) access_decode_i (
        .req  (req),
        .rsel (rsel),
        .wsel (wsel)
    );

    csr_trap_regs trap_regs_i (
        .clk     (clk),
        .resetn  (resetn),
        .wsel    (wsel),
        .wmask   (req.wmask),
        .wvalue  (req.wvalue),
        .trap    (trap),
        .ertn    (ertn),
        .hw_int  (hw_int),
        .ipi_int (ipi_int),
        .tpend   (tpend),
        .rd      (trap_rd),
        .has_int (has_int)
    );

    csr_timer timer_i (
        .clk    (clk),
        .resetn (resetn),
        .wsel   (wsel),
        .wmask  (req.wmask),
        .wvalue (req.wvalue),
        .rd     (timer_rd),
        .tpend  (tpend)
    );

    csr_save_bank #(.SAVE_NUM(SAVE_NUM)) save_bank_i (
        .clk    (clk),
        .wsel   (wsel),
        .wmask  (req.wmask),
        .wvalue (req.wvalue),
        .save   (save)
    );

    csr_read_mux #(.SAVE_NUM(SAVE_NUM)) read_mux_i (
        .rsel     (rsel),
        .trap_rd  (trap_rd),
        .timer_rd (timer_rd),
        .save     (save),
        .rvalue   (rvalue)
    );

endmodule

`default_nettype wire

/* tb/csr_stim.txt */
// op_a_b_c, one record per cycle. 01 write num mask value, 02 read num expected,
// 03 exception {esubcode[24:16],ecode[5:0]} pc vaddr, 04 ertn, 05 irq hw ipi,
// 06 idle cycles, 07 has_int expected, 08 end of test n, 00 end of records
// test 1: reset values, save registers, ECFG reserved bit
02_00000000_00000008_00000000
02_00000004_00000000_00000000
01_00000030_ffffffff_11111111
01_00000031_ffffffff_22222222
01_00000032_ffffffff_33333333
01_00000033_ffffffff_44444444
01_00000030_0000ffff_abcdabcd
01_00000031_ff00ff00_5a5a5a5a
01_00000032_0f0f0f0f_ffffffff
02_00000030_1111abcd_00000000
02_00000031_5a225a22_00000000
02_00000032_3f3f3f3f_00000000
02_00000033_44444444_00000000
01_00000004_ffffffff_00000400
02_00000004_00000000_00000000
02_00000034_00000000_00000000
08_00000001_00000000_00000000
// test 2: ADE fetch fault then ALE, each followed by ertn
01_00000000_ffffffff_00000007
03_00000008_1c000100_0000dead
02_00000000_00000008_00000000
02_00000001_00000007_00000000
02_00000005_00080000_00000000
02_00000006_1c000100_00000000
02_00000007_1c000100_00000000
04_00000000_00000000_00000000
02_00000000_0000000f_00000000
01_00000000_ffffffff_00000001
03_00000009_1c000200_00001003
02_00000001_00000001_00000000
02_00000005_00090000_00000000
02_00000007_00001003_00000000
04_00000000_00000000_00000000
02_00000000_00000009_00000000
08_00000002_00000000_00000000
// test 3: interrupt sampling, enables and software interrupts
01_00000004_ffffffff_00001fff
02_00000004_00001bff_00000000
05_00000005_00000001_00000000
02_00000005_00091014_00000000
07_00000000_00000000_00000000
01_00000000_ffffffff_00000004
07_00000001_00000000_00000000
01_00000004_ffffffff_00000000
07_00000000_00000000_00000000
01_00000005_00000003_00000002
01_00000004_ffffffff_00000002
07_00000001_00000000_00000000
02_00000005_00091016_00000000
05_00000000_00000000_00000000
01_00000005_00000003_00000000
07_00000000_00000000_00000000
08_00000003_00000000_00000000
// test 4: one-shot timer with initval 3
01_00000041_ffffffff_0000000d
02_00000042_0000000c_00000000
02_00000042_0000000b_00000000
02_00000042_0000000a_00000000
06_00000009_00000000_00000000
02_00000042_00000000_00000000
02_00000042_ffffffff_00000000
02_00000042_ffffffff_00000000
02_00000005_00090800_00000000
01_00000044_00000001_00000001
02_00000005_00090000_00000000
08_00000004_00000000_00000000
// test 5: periodic timer with initval 1, set beats clear
01_00000041_ffffffff_00000007
02_00000042_00000004_00000000
02_00000042_00000003_00000000
06_00000002_00000000_00000000
02_00000042_00000000_00000000
02_00000042_00000004_00000000
02_00000005_00090800_00000000
01_00000044_00000001_00000001
02_00000005_00090000_00000000
02_00000042_00000000_00000000
02_00000005_00090800_00000000
06_00000003_00000000_00000000
01_00000044_00000001_00000001
02_00000005_00090800_00000000
01_00000041_00000001_00000000
08_00000005_00000000_00000000
00_00000000_00000000_00000000

/* tb/csr_tb.sv */
// csr file testbench: replays the stimulus records and checks read words and has_int
`timescale 1ns/1ns
`default_nettype none

module csr_tb;
    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    localparam int DEPTH = 256;

    // record op codes, see the stimulus file header
    localparam logic [7:0] OP_END   = 8'h00;
    localparam logic [7:0] OP_WRITE = 8'h01;
    localparam logic [7:0] OP_READ  = 8'h02;
    localparam logic [7:0] OP_EXC   = 8'h03;
    localparam logic [7:0] OP_ERTN  = 8'h04;
    localparam logic [7:0] OP_INT   = 8'h05;
    localparam logic [7:0] OP_IDLE  = 8'h06;
    localparam logic [7:0] OP_HAS   = 8'h07;
    localparam logic [7:0] OP_TEST  = 8'h08;

    logic                clk;
    logic                resetn;
    csr_req_t            req;
    trap_evt_t           trap;
    logic                ertn;
    logic [HW_INT_W-1:0] hw_int;
    logic                ipi_int;
    logic [CSR_W-1:0]    rvalue;
    logic                has_int;

    logic [103:0] stim [DEPTH];  // op, a, b, c
    int           num_rec;
    int           limit;
    int           cycles;
    int           errors;
    int           checks;
    int           test_errors;
    int           tests;

    csr_top #(.SAVE_NUM(4)) csr_top_i (
        .clk     (clk),
        .resetn  (resetn),
        .req     (req),
        .trap    (trap),
        .ertn    (ertn),
        .hw_int  (hw_int),
        .ipi_int (ipi_int),
        .rvalue  (rvalue),
        .has_int (has_int)
    );

    always #4 clk = ~clk;

    // watchdog on the whole run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    function automatic string csr_name(input logic [CSR_NUM_W-1:0] num);
        case (num)
            CSR_CRMD:  return "rvalue(CRMD)";
            CSR_PRMD:  return "rvalue(PRMD)";
            CSR_ECFG:  return "rvalue(ECFG)";
            CSR_ESTAT: return "rvalue(ESTAT)";
            CSR_ERA:   return "rvalue(ERA)";
            CSR_BADV:  return "rvalue(BADV)";
            CSR_TCFG:  return "rvalue(TCFG)";
            CSR_TVAL:  return "rvalue(TVAL)";
            default:   return $sformatf("rvalue(csr %h)", num);
        endcase
    endfunction

    initial begin
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int          sum_idle;

        clk     = 1'b0;
        resetn  = 1'b0;
        req     = '0;
        trap    = '0;
        ertn    = 1'b0;
        hw_int  = '0;
        ipi_int = 1'b0;

        $readmemh("tb/csr_stim.txt", stim);
        num_rec  = 0;
        sum_idle = 0;
        while (num_rec < DEPTH && !$isunknown(stim[num_rec]) &&
               stim[num_rec][103:96] != OP_END) begin
            if (stim[num_rec][103:96] == OP_IDLE)
                sum_idle += int'(stim[num_rec][95:64]);
            num_rec++;
        end
        limit = num_rec + sum_idle + 50;
        if (num_rec == 0) begin
            $display("no stimulus records could be read");
            errors++;
        end

        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;

        for (int i = 0; i < num_rec; i++) begin
            @(posedge clk);
            #1;
            op = stim[i][103:96];
            a  = stim[i][95:64];
            b  = stim[i][63:32];
            c  = stim[i][31:0];
            req.we  = 1'b0;  // pulses last one slot
            trap.ex = 1'b0;
            ertn    = 1'b0;
            case (op)
                OP_WRITE: begin
                    req.we     = 1'b1;
                    req.num    = a[CSR_NUM_W-1:0];
                    req.wmask  = b;
                    req.wvalue = c;
                end
                OP_READ: begin
                    req.num = a[CSR_NUM_W-1:0];
                    #2;
                    compare(csr_name(req.num), rvalue, b);
                end
                OP_EXC: begin
                    trap.ex       = 1'b1;
                    trap.ecode    = a[5:0];
                    trap.esubcode = a[24:16];
                    trap.pc       = b;
                    trap.vaddr    = c;
                end
                OP_ERTN: ertn = 1'b1;
                OP_INT: begin
                    hw_int  = a[HW_INT_W-1:0];
                    ipi_int = b[0];
                end
                OP_IDLE: begin
                    if (a > 1)
                        repeat (a - 1) @(posedge clk);  // this slot counts as one
                end
                OP_HAS: begin
                    #2;
                    compare("has_int", {31'b0, has_int}, a);
                end
                OP_TEST: begin
                    $display("test %0d done, %0d errors", a, test_errors);
                    tests++;
                    test_errors = 0;
                end
                default: begin
                    $display("unknown op %h in record %0d", op, i);
                    errors++;
                end
            endcase
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* timer/csr_timer.sv */
// countdown timer: TCFG, TVAL and TICLR with the timer interrupt pending bit
`timescale 1ns/1ns
`default_nettype none

module csr_timer (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire csr_map_pkg::csr_sel_t   wsel,
    input  wire [csr_map_pkg::CSR_W-1:0] wmask,
    input  wire [csr_map_pkg::CSR_W-1:0] wvalue,
    output csr_map_pkg::timer_rd_t       rd,
    output logic                         tpend
);
    import csr_map_pkg::*;

    logic             tcfg_en;
    logic             tcfg_periodic;
    logic [29:0]      tcfg_initval;
    logic [CSR_W-1:0] cnt;
    tcfg_t            tcfg_nxt;   // TCFG as it will be after this write
    logic             ticlr_clr;
    logic             cnt_zero;

    always_comb begin
        rd.tcfg.initval  = tcfg_initval;
        rd.tcfg.periodic = tcfg_periodic;
        rd.tcfg.en       = tcfg_en;
        rd.tval          = cnt;
        rd.ticlr         = '0;        // write-only clear
    end

    assign tcfg_nxt  = tcfg_t'(csr_merge(rd.tcfg, wmask, wvalue));
    assign ticlr_clr = wsel.ticlr && wmask[0] && wvalue[0];
    assign cnt_zero  = (cnt == '0);

    always_ff @(posedge clk) begin
        if (!resetn)
            tcfg_en <= 1'b0;
        else if (wsel.tcfg)
            tcfg_en <= tcfg_nxt.en;
    end

    always_ff @(posedge clk) begin
        if (wsel.tcfg) begin
            tcfg_periodic <= tcfg_nxt.periodic;
            tcfg_initval  <= tcfg_nxt.initval;
        end
    end

    // load on enable write, stop at all ones
    always_ff @(posedge clk) begin
        if (!resetn)
            cnt <= '1;
        else if (wsel.tcfg && tcfg_nxt.en)
            cnt <= {tcfg_nxt.initval, 2'b0};
        else if (tcfg_en && cnt != '1) begin
            if (cnt_zero && tcfg_periodic)
                cnt <= {tcfg_initval, 2'b0};  // next period
            else
                cnt <= cnt - CSR_W'(1);
        end
    end

    // set wins over a same-cycle clear
    always_ff @(posedge clk) begin
        if (!resetn)
            tpend <= 1'b0;
        else if (cnt_zero)
            tpend <= 1'b1;
        else if (ticlr_clr)
            tpend <= 1'b0;
    end

endmodule

`default_nettype wire
